//--- rtl/psg_pkg.sv
/*
 * register map and voice routing of the three-voice sound generator.
 * the channel count is fixed at 3 because the register map depends on it.
 * volumes are linear; there is no envelope or noise source.
 */
package psg_pkg;

	// number of tone voices
	localparam int NUM_CH = 3;

	// clk_8 cycles per tone tick
	localparam int TICK_DIV = 4;

	// cpu register addresses
	typedef enum logic [2:0] {
		// 8-bit tone periods
		PERIOD_A = 3'd0,
		PERIOD_B = 3'd1,
		PERIOD_C = 3'd2,
		// 4-bit volumes, upper bits read back as zero
		VOL_A    = 3'd3,
		VOL_B    = 3'd4,
		VOL_C    = 3'd5,
		// voice enable mask, bit 0 is voice a
		MIX_EN   = 3'd6
		// address 7 is unused and reads zero
	} psg_reg_e;

	// stereo routing, bit i set means voice i feeds that side
	// voice a left only, b both sides, c right only
	localparam logic [NUM_CH-1:0] LEFT_MASK  = 3'b011;
	localparam logic [NUM_CH-1:0] RIGHT_MASK = 3'b110;

endpackage

//--- rtl/dac_pkg.sv
/*
 * widths shared by the voices, the stereo mixer and the sigma-delta DAC.
 * MIX_W holds the sum of two full-scale voices; a side never routes more.
 */
package dac_pkg;

	// per-voice volume width
	localparam int VOL_W = 4;

	// two-voice sum, 15 + 15 = 30 fits in 5 bits
	localparam int MIX_W = 5;

endpackage

//--- rtl/psg_regs.sv
/*
 * cpu register file of the sound generator plus the tone tick prescaler.
 * writes land on any edge with sel high and rw low; address 7 is ignored.
 * reads are registered: dout shows the register one cycle after the read
 * and holds it until the next read.
 */
`timescale 1ns/1ps

module psg_regs (
	input  logic                                      clk_8,
	input  logic                                      rst_n,
	input  logic                                      sel,
	input  logic                                      rw,
	input  logic [2:0]                                addr,
	input  logic [7:0]                                din,
	output logic [7:0]                                dout,
	output logic [psg_pkg::NUM_CH*8-1:0]              period,
	output logic [psg_pkg::NUM_CH*dac_pkg::VOL_W-1:0] volume,
	output logic [psg_pkg::NUM_CH-1:0]                enable,
	output logic                                      tick
);
	import psg_pkg::*;
	import dac_pkg::*;

	localparam int PW = $clog2(TICK_DIV);
	localparam logic [PW-1:0] PRESC_LAST = PW'(TICK_DIV - 1);

	logic [7:0]       period_q [NUM_CH];
	logic [VOL_W-1:0] vol_q [NUM_CH];
	logic [NUM_CH-1:0] en_q;
	logic [PW-1:0]    presc;
	logic [7:0]       rd_data;
	psg_reg_e         reg_sel;

	assign reg_sel = psg_reg_e'(addr);

	// cpu writes, unused upper bits of volume and mask are dropped
	always_ff @(posedge clk_8) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CH; i++) begin
				period_q[i] <= '0;
				vol_q[i] <= '0;
			end
			en_q <= '0;
		end else if (sel && !rw) begin
			case (reg_sel)
				PERIOD_A: period_q[0] <= din;
				PERIOD_B: period_q[1] <= din;
				PERIOD_C: period_q[2] <= din;
				VOL_A:    vol_q[0] <= din[VOL_W-1:0];
				VOL_B:    vol_q[1] <= din[VOL_W-1:0];
				VOL_C:    vol_q[2] <= din[VOL_W-1:0];
				MIX_EN:   en_q <= din[NUM_CH-1:0];
				// address 7, nothing to write
				default: ;
			endcase
		end
	end

	// readback mux, fields zero extended to the byte
	always_comb begin
		case (reg_sel)
			PERIOD_A: rd_data = period_q[0];
			PERIOD_B: rd_data = period_q[1];
			PERIOD_C: rd_data = period_q[2];
			VOL_A:    rd_data = 8'(vol_q[0]);
			VOL_B:    rd_data = 8'(vol_q[1]);
			VOL_C:    rd_data = 8'(vol_q[2]);
			MIX_EN:   rd_data = 8'(en_q);
			default:  rd_data = 8'h00;
		endcase
	end

	// dout only moves on a read
	always_ff @(posedge clk_8) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (sel && rw) begin
			dout <= rd_data;
		end
	end

	// divide-by-TICK_DIV prescaler, tick is a registered one-cycle strobe
	always_ff @(posedge clk_8) begin
		if (!rst_n) begin
			presc <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (presc == PRESC_LAST);
			if (presc == PRESC_LAST)
				presc <= '0;
			else
				presc <= presc + 1'b1;
		end
	end

	// flatten the register arrays onto the voice buses
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			period[i*8 +: 8] = period_q[i];
			volume[i*VOL_W +: VOL_W] = vol_q[i];
		end
	end

	assign enable = en_q;

endmodule

//--- rtl/tone_channel.sv
/*
 * one square-wave voice. half-period is period ticks, so period * TICK_DIV
 * clk_8 cycles. a period of 0 parks the square high, giving a constant
 * level. volume gating is linear.
 */
`timescale 1ns/1ps

module tone_channel (
	input  logic                      clk_8,
	input  logic                      rst_n,
	input  logic                      tick,
	input  logic [7:0]                period,
	input  logic [dac_pkg::VOL_W-1:0] volume,
	input  logic                      enable,
	output logic [dac_pkg::VOL_W-1:0] level
);

	logic [7:0] cnt;
	logic       sq;
	logic       wrap;

	// >= so that lowering the period below the count still wraps at once
	assign wrap = (cnt >= period - 8'd1);

	// period counter and square flip-flop, both step on tick only
	always_ff @(posedge clk_8) begin
		if (!rst_n) begin
			cnt <= '0;
			sq <= 1'b0;
		end else if (tick) begin
			if (period == 8'd0) begin
				// hold high, counter parked
				cnt <= '0;
				sq <= 1'b1;
			end else if (wrap) begin
				cnt <= '0;
				sq <= ~sq;
			end else begin
				cnt <= cnt + 8'd1;
			end
		end
	end

	// gated volume, registered every cycle
	// so volume and enable changes reach the mixer one cycle later
	always_ff @(posedge clk_8) begin
		if (!rst_n)
			level <= '0;
		else if (sq && enable)
			level <= volume;
		else
			level <= '0;
	end

endmodule

//--- rtl/stereo_dac.sv
/*
 * stereo mixer feeding two first-order sigma-delta modulators.
 * DAC_W must be at least MIX_W; the routed sum is scaled up to DAC_W bits.
 * for a constant input v, each output carries exactly v ones per 2^DAC_W
 * cycles. the outputs are raw bitstreams and need an external RC filter.
 */
`timescale 1ns/1ps

module stereo_dac #(
	parameter int DAC_W = 8
) (
	input  logic                                      clk_8,
	input  logic                                      rst_n,
	input  logic [psg_pkg::NUM_CH*dac_pkg::VOL_W-1:0] levels,
	output logic                                      audio_l,
	output logic                                      audio_r
);
	import psg_pkg::*;
	import dac_pkg::*;

	// left-justify the mix inside the accumulator width
	localparam int SHIFT = DAC_W - MIX_W;

	logic [MIX_W-1:0] mix [2];
	logic [DAC_W-1:0] dac_in [2];
	logic [DAC_W-1:0] acc [2];
	logic [DAC_W:0]   acc_sum [2];

	// sum the voices selected by a routing mask
	function automatic logic [MIX_W-1:0] routed_sum(
		input logic [NUM_CH-1:0]       mask,
		input logic [NUM_CH*VOL_W-1:0] lv
	);
		logic [MIX_W-1:0] s;
		s = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			if (mask[i])
				s = s + MIX_W'(lv[i*VOL_W +: VOL_W]);
		end
		return s;
	endfunction

	// side 0 is left, side 1 is right
	assign mix[0] = routed_sum(LEFT_MASK, levels);
	assign mix[1] = routed_sum(RIGHT_MASK, levels);

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			dac_in[s] = DAC_W'(mix[s]) << SHIFT;
			// one extra bit catches the carry
			acc_sum[s] = {1'b0, acc[s]} + {1'b0, dac_in[s]};
		end
	end

	// accumulators wrap mod 2^DAC_W, carry out becomes the bitstream
	always_ff @(posedge clk_8) begin
		if (!rst_n) begin
			acc[0] <= '0;
			acc[1] <= '0;
			audio_l <= 1'b0;
			audio_r <= 1'b0;
		end else begin
			acc[0] <= acc_sum[0][DAC_W-1:0];
			acc[1] <= acc_sum[1][DAC_W-1:0];
			audio_l <= acc_sum[0][DAC_W];
			audio_r <= acc_sum[1][DAC_W];
		end
	end

endmodule

//--- rtl/audio_top.sv
/*
 * three-voice sound generator: register file, tone voices, stereo DAC.
 * single clock domain on clk_8, synchronous active-low reset.
 * audio_l and audio_r are 1-bit sigma-delta streams at the clk_8 rate.
 */
`timescale 1ns/1ps

module audio_top #(
	parameter int DAC_W = 8
) (
	input  logic       clk_8,
	input  logic       rst_n,
	// cpu port, rw high means read
	input  logic       sel,
	input  logic       rw,
	input  logic [2:0] addr,
	input  logic [7:0] din,
	output logic [7:0] dout,
	// bitstream outputs
	output logic       audio_l,
	output logic       audio_r
);
	import psg_pkg::*;
	import dac_pkg::*;

	logic [NUM_CH*8-1:0]     period;
	logic [NUM_CH*VOL_W-1:0] volume;
	logic [NUM_CH-1:0]       enable;
	logic                    tick;
	// packed voice levels, voice a in the low bits
	logic [NUM_CH*VOL_W-1:0] levels;

	psg_regs u_regs (
		.clk_8  (clk_8),
		.rst_n  (rst_n),
		.sel    (sel),
		.rw     (rw),
		.addr   (addr),
		.din    (din),
		.dout   (dout),
		.period (period),
		.volume (volume),
		.enable (enable),
		.tick   (tick)
	);

	// one voice per channel slice
	for (genvar i = 0; i < NUM_CH; i++) begin : g_voice
		tone_channel u_tone (
			.clk_8  (clk_8),
			.rst_n  (rst_n),
			.tick   (tick),
			.period (period[i*8 +: 8]),
			.volume (volume[i*VOL_W +: VOL_W]),
			.enable (enable[i]),
			.level  (levels[i*VOL_W +: VOL_W])
		);
	end

	stereo_dac #(
		.DAC_W (DAC_W)
	) u_dac (
		.clk_8   (clk_8),
		.rst_n   (rst_n),
		.levels  (levels),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

//--- tb/audio_chk.sv
/*
 * timing rules of audio_top, bound into every instance.
 * tick and dout rules wait 15 cycles after reset release.
 * TICK_DIV comes from psg_pkg.
 */
`timescale 1ns/1ps

module audio_chk (
	input logic       clk_8,
	input logic       rst_n,
	input logic       sel,
	input logic       rw,
	input logic [7:0] dout,
	input logic       tick,
	input logic       audio_l,
	input logic       audio_r
);
	import psg_pkg::*;

	logic [3:0] warm;
	logic       live;
	int         fails = 0;

	// cycles since reset release, saturating
	always_ff @(posedge clk_8) begin
		if (!rst_n)
			warm <= '0;
		else if (warm != 4'hf)
			warm <= warm + 4'd1;
	end

	assign live = rst_n && (warm == 4'hf);

	// next tick exactly TICK_DIV cycles after the last
	a_tick_period: assert property (@(posedge clk_8) disable iff (!live)
		$past(tick, TICK_DIV) |-> tick)
	else begin
		fails++;
		$error("tick did not repeat after TICK_DIV cycles");
	end

	// no tick in between
	for (genvar k = 1; k < TICK_DIV; k++) begin : g_tick_gap
		a_tick_gap: assert property (@(posedge clk_8) disable iff (!live)
			$past(tick, k) |-> !tick)
		else begin
			fails++;
			$error("tick came early, %0d cycles after the last", k);
		end
	end

	// bitstreams cleared by reset
	a_quiet_in_reset: assert property (@(posedge clk_8)
		!rst_n |=> (!audio_l && !audio_r))
	else begin
		fails++;
		$error("audio output high while in reset");
	end

	// dout moves only the cycle after a read
	a_dout_on_read: assert property (@(posedge clk_8) disable iff (!live)
		!$stable(dout) |-> $past(sel && rw))
	else begin
		fails++;
		$error("dout changed without a read");
	end

endmodule

bind audio_top audio_chk u_chk (
	.clk_8   (clk_8),
	.rst_n   (rst_n),
	.sel     (sel),
	.rw      (rw),
	.dout    (dout),
	.tick    (tick),
	.audio_l (audio_l),
	.audio_r (audio_r)
);

//--- tb/audio_tb.sv
/*
 * testbench for audio_top, run from the project root so that
 * tb/audio_stimulus.txt is found. density windows assume DAC_W = 8,
 * one accumulator wrap every 256 cycles. the random sweep repeats exactly.
 */
`timescale 1ns/1ps

module audio_tb;
	import psg_pkg::*;

	localparam int DAC_W = 8;
	// cycles allowed for a register change to reach the bitstreams
	localparam int SETTLE = 8;

	typedef enum int {OP_W, OP_R, OP_M, OP_X} op_e;

	logic       clk_8;
	logic       rst_n;
	logic       sel;
	logic       rw;
	logic [2:0] addr;
	logic [7:0] din;
	logic [7:0] dout;
	logic       audio_l;
	logic       audio_r;

	// parsed commands, one entry per file line
	op_e         op_q[$];
	int          arg_a[$];
	int          arg_b[$];
	int          arg_c[$];
	int          arg_d[$];
	// expected register contents for the random sweep
	logic [7:0]  shadow [8];
	logic [31:0] lcg_state;
	int          errors;
	int          cycles = 0;
	int          cycle_limit = 2000;

	audio_top #(
		.DAC_W (DAC_W)
	) UUT (
		.clk_8   (clk_8),
		.rst_n   (rst_n),
		.sel     (sel),
		.rw      (rw),
		.addr    (addr),
		.din     (din),
		.dout    (dout),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	// 8 ns clock
	initial begin
		clk_8 = 1'b0;
		forever #4 clk_8 = ~clk_8;
	end

	// run guard, limit is the sum of the M windows plus 2000
	always @(posedge clk_8) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// readable bits of each register
	function automatic logic [7:0] field_mask(input logic [2:0] a);
		case (psg_reg_e'(a))
			PERIOD_A, PERIOD_B, PERIOD_C: return 8'hff;
			VOL_A, VOL_B, VOL_C:          return 8'h0f;
			MIX_EN:                       return 8'((1 << NUM_CH) - 1);
			default:                      return 8'h00;
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int abs_diff(input int x, input int y);
		return (x > y) ? x - y : y - x;
	endfunction

	// write lands on the second edge
	task automatic write_reg(input logic [2:0] a, input logic [7:0] d);
		@(posedge clk_8);
		sel <= 1'b1;
		rw <= 1'b0;
		addr <= a;
		din <= d;
		@(posedge clk_8);
		sel <= 1'b0;
		shadow[a] = d & field_mask(a);
	endtask

	// dout is valid one cycle after the read edge
	task automatic read_check(input logic [2:0] a, input logic [7:0] exp);
		@(posedge clk_8);
		sel <= 1'b1;
		rw <= 1'b1;
		addr <= a;
		@(posedge clk_8);
		sel <= 1'b0;
		rw <= 1'b0;
		@(posedge clk_8);
		assert (dout === exp) else begin
			errors++;
			$display("** Error at %0t: read of address %0d gave %02h, expected %02h",
				$time, a, dout, exp);
		end
	endtask

	// count ones on both sides over n cycles
	task automatic measure_density(input int n, input int exp_l, input int exp_r,
		input int tol);
		int ones_l;
		int ones_r;
		int tol_l;
		int tol_r;
		ones_l = 0;
		ones_r = 0;
		// a silent side sees a constant zero input, so its count is exact
		tol_l = (exp_l == 0) ? 0 : tol;
		tol_r = (exp_r == 0) ? 0 : tol;
		repeat (SETTLE) @(posedge clk_8);
		repeat (n) begin
			@(posedge clk_8);
			if (audio_l === 1'b1)
				ones_l++;
			if (audio_r === 1'b1)
				ones_r++;
		end
		assert (abs_diff(ones_l, exp_l) <= tol_l) else begin
			errors++;
			$display("** Error at %0t: left gave %0d ones in %0d cycles, expected %0d",
				$time, ones_l, n, exp_l);
		end
		assert (abs_diff(ones_r, exp_r) <= tol_r) else begin
			errors++;
			$display("** Error at %0t: right gave %0d ones in %0d cycles, expected %0d",
				$time, ones_r, n, exp_r);
		end
	endtask

	// random writes, each followed by a read of a random address
	task automatic random_sweep(input int n);
		logic [2:0] wa;
		logic [7:0] wd;
		logic [2:0] ra;
		for (int i = 0; i < n; i++) begin
			lcg_state = lcg_next(lcg_state);
			wa = lcg_state[18:16];
			wd = lcg_state[30:23];
			write_reg(wa, wd);
			lcg_state = lcg_next(lcg_state);
			ra = lcg_state[18:16];
			read_check(ra, shadow[ra]);
		end
	endtask

	task automatic push_cmd(input op_e op, input int a, input int b, input int c,
		input int d);
		op_q.push_back(op);
		arg_a.push_back(a);
		arg_b.push_back(b);
		arg_c.push_back(c);
		arg_d.push_back(d);
	endtask

	task automatic load_stimulus();
		int                fd;
		int                n;
		logic [63:0]       tok;
		logic [8*128-1:0]  rest;
		int                a;
		int                b;
		int                c;
		int                d;
		fd = $fopen("tb/audio_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tb/audio_stimulus.txt");
			$display("Errors found");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tok);
				if (n == 1) begin
					a = 0;
					b = 0;
					c = 0;
					d = 0;
					if (tok == "#") begin
						n = $fgets(rest, fd);
					end else if (tok == "W") begin
						n = $fscanf(fd, "%h %h", a, b);
						push_cmd(OP_W, a, b, c, d);
					end else if (tok == "R") begin
						n = $fscanf(fd, "%h %h", a, b);
						push_cmd(OP_R, a, b, c, d);
					end else if (tok == "M") begin
						n = $fscanf(fd, "%d %d %d %d", a, b, c, d);
						push_cmd(OP_M, a, b, c, d);
						cycle_limit += a;
					end else if (tok == "X") begin
						n = $fscanf(fd, "%d", a);
						push_cmd(OP_X, a, b, c, d);
					end else begin
						errors++;
						$display("unknown command in the stimulus file");
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_commands();
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				OP_W:    write_reg(3'(arg_a[i]), 8'(arg_b[i]));
				OP_R:    read_check(3'(arg_a[i]), 8'(arg_b[i]));
				OP_M:    measure_density(arg_a[i], arg_b[i], arg_c[i], arg_d[i]);
				OP_X:    random_sweep(arg_a[i]);
				default: ;
			endcase
		end
	endtask

	initial begin
		sel = 1'b0;
		rw = 1'b0;
		addr = 3'd0;
		din = 8'h00;
		rst_n = 1'b0;
		errors = 0;
		lcg_state = 32'd1;
		for (int i = 0; i < 8; i++)
			shadow[i] = 8'h00;
		load_stimulus();
		// reset held over three edges
		repeat (3) @(posedge clk_8);
		rst_n <= 1'b1;
		run_commands();
		$display("value errors: %0d, assertion failures: %0d", errors, UUT.u_chk.fails);
		if (errors == 0 && UUT.u_chk.fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- tb/audio_stimulus.txt
# one command per line, W and R fields in hex, M and X fields in decimal
# W addr data | R addr expected | M cycles exp_left exp_right tol | X count
# reset state, every register 0 and both outputs low
R 0 00
R 1 00
R 2 00
R 3 00
R 4 00
R 5 00
R 6 00
R 7 00
M 256 0 0 0
# readback masked to the field width, address 7 ignored
W 0 a5
R 0 a5
W 2 3c
R 2 3c
W 4 ff
R 4 0f
W 6 ff
R 6 07
W 7 55
R 7 00
# constant levels with period 0, left (a+b)*8, right (b+c)*8
W 0 00
W 2 00
W 3 05
W 4 03
W 5 09
W 6 07
M 256 64 96 0
W 3 0f
W 4 0f
W 5 0f
M 256 240 240 0
# enable mask removes voices
W 3 05
W 4 03
W 5 09
W 6 05
M 256 40 72 0
W 6 02
M 256 24 24 0
W 6 00
M 256 0 0 0
# voice a toggling, period 32 gives a 256 cycle square
W 3 08
W 0 20
W 6 01
M 2048 256 0 1
# random writes and readback
X 40

//--- compile.f
rtl/psg_pkg.sv
rtl/dac_pkg.sv
rtl/psg_regs.sv
rtl/tone_channel.sv
rtl/stereo_dac.sv
rtl/audio_top.sv
tb/audio_chk.sv
tb/audio_tb.sv

//--- Makefile
# Verilator build and run of the three-voice sound generator testbench
# any variable below can be overridden, e.g. make test TOP=audio_tb LOG=run.log

VERILATOR ?= verilator
TOP       ?= audio_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= No errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS PASS_MSG"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
